// File: rtl/emu_consts.svh
`ifndef EMU_CONSTS_SVH
`define EMU_CONSTS_SVH

// Register bus widths
`define EMU_ADDR_W          10
`define EMU_DATA_W          32

// Command FIFO depth, equal to the host's initial command credits
`define EMU_CMD_DEPTH       4
// Response credits held by the port after reset
`define EMU_RSP_CREDITS     2

// Target-side counts
`define EMU_TRIG_COUNT      8
`define EMU_RESET_COUNT     4
`define EMU_SCAN_WORDS      8

// Control and status word addresses
`define EMU_REG_RUN_CTRL    10'h000
`define EMU_REG_TICK_STEP   10'h001
`define EMU_REG_TICK_CNT_LO 10'h002
`define EMU_REG_TICK_CNT_HI 10'h003
`define EMU_REG_SCAN_CTRL   10'h004

// Trigger and reset word addresses
`define EMU_REG_TRIG_STAT   10'h040
`define EMU_REG_TRIG_EN     10'h041
`define EMU_REG_RESET_CTRL  10'h042

// Scan buffer base, words 0x080 to 0x087
`define EMU_REG_SCAN_BUF    10'h080

`endif

// File: rtl/emu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "emu_consts.svh"

module emu_ctrl (
    input  logic                                 host_clk,
    input  logic                                 host_rst,
    input  logic                                 reg_wen,
    input  logic                                 reg_ren,
    input  logic [`EMU_ADDR_W-1:0]               reg_addr,
    input  logic [`EMU_DATA_W-1:0]               reg_wdata,
    output logic [`EMU_DATA_W-1:0]               reg_rdata,
    input  logic [`EMU_TRIG_COUNT-1:0]           trig,
    output logic                                 run_mode,
    output logic                                 scan_mode,
    output logic [`EMU_RESET_COUNT-1:0]          rst,
    output logic                                 buf_wen,
    output logic [$clog2(`EMU_SCAN_WORDS)-1:0]   buf_addr,
    output logic [`EMU_DATA_W-1:0]               buf_wdata,
    input  logic [`EMU_DATA_W-1:0]               buf_rdata,
    output logic                                 scan_start,
    input  logic                                 scan_busy
);

    localparam int SCAN_AW = $clog2(`EMU_SCAN_WORDS);
    localparam logic [`EMU_ADDR_W-1:0] SCAN_BUF_BASE = `EMU_REG_SCAN_BUF;

    logic [`EMU_DATA_W-1:0]     tick_step;
    logic [2*`EMU_DATA_W-1:0]   tick_cnt;
    logic [`EMU_TRIG_COUNT-1:0] trig_en;
    logic [`EMU_TRIG_COUNT-1:0] trig_stat;

    logic run_wr;
    logic resume_wr;
    logic pause_wr;
    logic trig_hit;
    logic step_done;
    logic sel_scan_buf;

    // Address decode for writes
    assign run_wr       = reg_wen && (reg_addr == `EMU_REG_RUN_CTRL);
    assign sel_scan_buf = (reg_addr[`EMU_ADDR_W-1:SCAN_AW] ==
                           SCAN_BUF_BASE[`EMU_ADDR_W-1:SCAN_AW]);

    // Resume only from pause and never during a scan
    assign resume_wr = run_wr && reg_wdata[0] && !run_mode && !scan_busy;
    assign pause_wr  = run_wr && !reg_wdata[0];
    assign trig_hit  = |(trig & trig_en);
    assign step_done = (tick_step == `EMU_DATA_W'(1));

    // Target clock enable, one tick per cycle while high
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            run_mode <= 1'b0;
        end else if (!run_mode) begin
            run_mode <= resume_wr;
        end else if (pause_wr || trig_hit || step_done) begin
            run_mode <= 1'b0;
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            scan_mode <= 1'b0;
        end else if (run_wr) begin
            scan_mode <= reg_wdata[1];
        end
    end

    // Step count, loaded while paused and counted down per tick
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            tick_step <= '0;
        end else if (run_mode) begin
            if (tick_step != '0) begin
                tick_step <= tick_step - 1'b1;
            end
        end else if (reg_wen && reg_addr == `EMU_REG_TICK_STEP) begin
            tick_step <= reg_wdata;
        end
    end

    // 64-bit tick counter, preset in two halves while paused
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            tick_cnt <= '0;
        end else if (run_mode) begin
            tick_cnt <= tick_cnt + 1'b1;
        end else if (reg_wen) begin
            if (reg_addr == `EMU_REG_TICK_CNT_LO) begin
                tick_cnt[`EMU_DATA_W-1:0] <= reg_wdata;
            end
            if (reg_addr == `EMU_REG_TICK_CNT_HI) begin
                tick_cnt[2*`EMU_DATA_W-1:`EMU_DATA_W] <= reg_wdata;
            end
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            trig_en <= '0;
            rst     <= '0;
        end else if (reg_wen) begin
            if (reg_addr == `EMU_REG_TRIG_EN) begin
                trig_en <= reg_wdata[`EMU_TRIG_COUNT-1:0];
            end
            if (reg_addr == `EMU_REG_RESET_CTRL) begin
                rst <= reg_wdata[`EMU_RESET_COUNT-1:0];
            end
        end
    end

    // Sticky record of which enabled triggers fired in this run
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            trig_stat <= '0;
        end else if (resume_wr) begin
            trig_stat <= '0;
        end else if (run_mode) begin
            trig_stat <= trig_stat | (trig & trig_en);
        end
    end

    // Scan engine side, buffer locked while a scan is in flight
    assign scan_start = reg_wen && (reg_addr == `EMU_REG_SCAN_CTRL) && reg_wdata[0]
                        && !run_mode && !scan_busy;
    assign buf_wen    = reg_wen && sel_scan_buf && !scan_busy;
    assign buf_addr   = reg_addr[SCAN_AW-1:0];
    assign buf_wdata  = reg_wdata;

    // Read mux
    always_comb begin
        reg_rdata = '0;
        if (reg_ren) begin
            case (reg_addr)
                `EMU_REG_RUN_CTRL: begin
                    reg_rdata[0] = run_mode;
                    reg_rdata[1] = scan_mode;
                end
                `EMU_REG_TICK_STEP:   reg_rdata = tick_step;
                `EMU_REG_TICK_CNT_LO: reg_rdata = tick_cnt[`EMU_DATA_W-1:0];
                `EMU_REG_TICK_CNT_HI: reg_rdata = tick_cnt[2*`EMU_DATA_W-1:`EMU_DATA_W];
                `EMU_REG_SCAN_CTRL:   reg_rdata[0] = scan_busy;
                `EMU_REG_TRIG_STAT:   reg_rdata[`EMU_TRIG_COUNT-1:0] = trig_stat;
                `EMU_REG_TRIG_EN:     reg_rdata[`EMU_TRIG_COUNT-1:0] = trig_en;
                `EMU_REG_RESET_CTRL:  reg_rdata[`EMU_RESET_COUNT-1:0] = rst;
                default: begin
                    if (sel_scan_buf && !scan_busy) begin
                        reg_rdata = buf_rdata;
                    end
                end
            endcase
        end
    end

    // Target stays paused from scan start until the engine lets go
    a_scan_paused: assert property (@(posedge host_clk) disable iff (host_rst)
        (scan_start || scan_busy) |-> !run_mode);

endmodule

`default_nettype wire

// File: rtl/emu_pkg.sv
package emu_pkg;

    // Host command opcode
    typedef enum logic {
        CMD_WRITE = 1'b0,
        CMD_READ  = 1'b1
    } cmd_op_e;

    // Scan sequencer states
    // IDLE waits for a start, SHIFT swaps one word per cycle,
    // DONE is the closing cycle before the buffer is released
    typedef enum logic [1:0] {
        SCAN_IDLE  = 2'd0,
        SCAN_SHIFT = 2'd1,
        SCAN_DONE  = 2'd2
    } scan_state_e;

endpackage

// File: rtl/emu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "emu_consts.svh"

module emu_top (
    input  logic                        host_clk,
    input  logic                        host_rst,
    // Host command and response channels
    input  logic                        cmd_valid,
    input  emu_pkg::cmd_op_e            cmd_op,
    input  logic [`EMU_ADDR_W-1:0]      cmd_addr,
    input  logic [`EMU_DATA_W-1:0]      cmd_wdata,
    output logic                        cmd_credit,
    output logic                        rsp_valid,
    output logic [`EMU_DATA_W-1:0]      rsp_rdata,
    input  logic                        rsp_credit,
    // Emulated target
    output logic                        run_mode,
    output logic                        scan_mode,
    output logic [`EMU_RESET_COUNT-1:0] rst,
    output logic                        ff_se,
    output logic [`EMU_DATA_W-1:0]      ff_di,
    input  logic [`EMU_DATA_W-1:0]      ff_do,
    input  logic [`EMU_TRIG_COUNT-1:0]  trig
);

    logic                               reg_wen;
    logic                               reg_ren;
    logic [`EMU_ADDR_W-1:0]             reg_addr;
    logic [`EMU_DATA_W-1:0]             reg_wdata;
    logic [`EMU_DATA_W-1:0]             reg_rdata;
    logic                               buf_wen;
    logic [$clog2(`EMU_SCAN_WORDS)-1:0] buf_addr;
    logic [`EMU_DATA_W-1:0]             buf_wdata;
    logic [`EMU_DATA_W-1:0]             buf_rdata;
    logic                               scan_start;
    logic                               scan_busy;

    host_cmd_port i_host_cmd_port (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_credit (rsp_credit),
        .reg_wen    (reg_wen),
        .reg_ren    (reg_ren),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata)
    );

    emu_ctrl i_emu_ctrl (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .reg_wen    (reg_wen),
        .reg_ren    (reg_ren),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .trig       (trig),
        .run_mode   (run_mode),
        .scan_mode  (scan_mode),
        .rst        (rst),
        .buf_wen    (buf_wen),
        .buf_addr   (buf_addr),
        .buf_wdata  (buf_wdata),
        .buf_rdata  (buf_rdata),
        .scan_start (scan_start),
        .scan_busy  (scan_busy)
    );

    scan_chain_ctrl i_scan_chain_ctrl (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .buf_wen    (buf_wen),
        .buf_addr   (buf_addr),
        .buf_wdata  (buf_wdata),
        .buf_rdata  (buf_rdata),
        .scan_start (scan_start),
        .scan_busy  (scan_busy),
        .ff_se      (ff_se),
        .ff_di      (ff_di),
        .ff_do      (ff_do)
    );

endmodule

`default_nettype wire

// File: rtl/host_cmd_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "emu_consts.svh"

module host_cmd_port (
    input  logic                   host_clk,
    input  logic                   host_rst,
    input  logic                   cmd_valid,
    input  emu_pkg::cmd_op_e       cmd_op,
    input  logic [`EMU_ADDR_W-1:0] cmd_addr,
    input  logic [`EMU_DATA_W-1:0] cmd_wdata,
    output logic                   cmd_credit,
    output logic                   rsp_valid,
    output logic [`EMU_DATA_W-1:0] rsp_rdata,
    input  logic                   rsp_credit,
    output logic                   reg_wen,
    output logic                   reg_ren,
    output logic [`EMU_ADDR_W-1:0] reg_addr,
    output logic [`EMU_DATA_W-1:0] reg_wdata,
    input  logic [`EMU_DATA_W-1:0] reg_rdata
);
    import emu_pkg::*;

    localparam int PTR_W = $clog2(`EMU_CMD_DEPTH);
    localparam int CNT_W = $clog2(`EMU_CMD_DEPTH + 1);
    localparam int RSP_W = $clog2(`EMU_RSP_CREDITS + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`EMU_CMD_DEPTH - 1);

    cmd_op_e                fifo_op    [`EMU_CMD_DEPTH];
    logic [`EMU_ADDR_W-1:0] fifo_addr  [`EMU_CMD_DEPTH];
    logic [`EMU_DATA_W-1:0] fifo_wdata [`EMU_CMD_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_cnt;
    logic [RSP_W-1:0] rsp_cnt;
    logic             head_is_read;
    logic             pop;

    // Head of queue drives the register bus in the pop cycle
    assign head_is_read = (fifo_op[rd_ptr] == CMD_READ);
    assign pop          = (fifo_cnt != '0) && (!head_is_read || rsp_cnt != '0);

    assign reg_wen   = pop && !head_is_read;
    assign reg_ren   = pop && head_is_read;
    assign reg_addr  = fifo_addr[rd_ptr];
    assign reg_wdata = fifo_wdata[rd_ptr];

    // Entry storage
    always_ff @(posedge host_clk) begin
        if (cmd_valid) begin
            fifo_op[wr_ptr]    <= cmd_op;
            fifo_addr[wr_ptr]  <= cmd_addr;
            fifo_wdata[wr_ptr] <= cmd_wdata;
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_cnt   <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({cmd_valid, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
            // Every freed slot goes back to the host as a credit
            cmd_credit <= pop;
        end
    end

    // Response credit is spent when the read pops
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            rsp_cnt   <= RSP_W'(`EMU_RSP_CREDITS);
            rsp_valid <= 1'b0;
        end else begin
            case ({reg_ren, rsp_credit})
                2'b10:   rsp_cnt <= rsp_cnt - 1'b1;
                2'b01:   rsp_cnt <= rsp_cnt + 1'b1;
                default: rsp_cnt <= rsp_cnt;
            endcase
            rsp_valid <= reg_ren;
        end
    end

    always_ff @(posedge host_clk) begin
        if (reg_ren) begin
            rsp_rdata <= reg_rdata;
        end
    end

    // Host must hold a credit, so a full FIFO never sees a push
    a_no_push_full: assert property (@(posedge host_clk) disable iff (host_rst)
        cmd_valid |-> fifo_cnt != CNT_W'(`EMU_CMD_DEPTH));

    // Host never returns more response credits than it was given
    a_rsp_credit_max: assert property (@(posedge host_clk) disable iff (host_rst)
        rsp_cnt <= RSP_W'(`EMU_RSP_CREDITS));

endmodule

`default_nettype wire

// File: rtl/scan_chain_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "emu_consts.svh"

module scan_chain_ctrl (
    input  logic                                 host_clk,
    input  logic                                 host_rst,
    input  logic                                 buf_wen,
    input  logic [$clog2(`EMU_SCAN_WORDS)-1:0]   buf_addr,
    input  logic [`EMU_DATA_W-1:0]               buf_wdata,
    output logic [`EMU_DATA_W-1:0]               buf_rdata,
    input  logic                                 scan_start,
    output logic                                 scan_busy,
    output logic                                 ff_se,
    output logic [`EMU_DATA_W-1:0]               ff_di,
    input  logic [`EMU_DATA_W-1:0]               ff_do
);
    import emu_pkg::*;

    localparam int SCAN_AW = $clog2(`EMU_SCAN_WORDS);
    localparam logic [SCAN_AW-1:0] LAST_WORD = SCAN_AW'(`EMU_SCAN_WORDS - 1);

    logic [`EMU_DATA_W-1:0] scan_buf [`EMU_SCAN_WORDS];

    scan_state_e      state;
    logic [SCAN_AW-1:0] shift_cnt;

    assign ff_se     = (state == SCAN_SHIFT);
    assign scan_busy = (state != SCAN_IDLE);
    // Bottom of the ring goes out to the target chain
    assign ff_di     = scan_buf[0];
    assign buf_rdata = scan_buf[buf_addr];

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            state     <= SCAN_IDLE;
            shift_cnt <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    if (scan_start) begin
                        state     <= SCAN_SHIFT;
                        shift_cnt <= '0;
                    end
                end
                SCAN_SHIFT: begin
                    shift_cnt <= shift_cnt + 1'b1;
                    if (shift_cnt == LAST_WORD) begin
                        state <= SCAN_DONE;
                    end
                end
                SCAN_DONE: begin
                    state <= SCAN_IDLE;
                end
                default: begin
                    state <= SCAN_IDLE;
                end
            endcase
        end
    end

    // Ring shift toward word 0 with target data entering at the top
    always_ff @(posedge host_clk) begin
        if (state == SCAN_SHIFT) begin
            for (int i = 0; i < `EMU_SCAN_WORDS - 1; i++) begin
                scan_buf[i] <= scan_buf[i+1];
            end
            scan_buf[`EMU_SCAN_WORDS-1] <= ff_do;
        end else if (buf_wen) begin
            scan_buf[buf_addr] <= buf_wdata;
        end
    end

    // One full pass per start and then a single closing busy cycle
    a_scan_pass: assert property (@(posedge host_clk) disable iff (host_rst)
        scan_start |=> ff_se [*`EMU_SCAN_WORDS] ##1 (!ff_se && scan_busy) ##1 !scan_busy);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the emu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_emu_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_emu_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// File: sim/emu_target_model.sv
`timescale 1ns/1ps

`include "emu_consts.svh"

module emu_target_model (
    input  logic                       host_clk,
    input  logic                       host_rst,
    input  logic                       run_mode,
    input  logic                       ff_se,
    input  logic [`EMU_DATA_W-1:0]     ff_di,
    output logic [`EMU_DATA_W-1:0]     ff_do,
    output logic [`EMU_TRIG_COUNT-1:0] trig
);

    logic [`EMU_DATA_W-1:0] chain [`EMU_SCAN_WORDS];

    // Bottom word leaves first on a scan
    assign ff_do = chain[0];

    // Only trig[0] is wired, it fires when the two low words match
    assign trig = {{(`EMU_TRIG_COUNT-1){1'b0}}, (chain[0] == chain[1])};

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            for (int i = 0; i < `EMU_SCAN_WORDS; i++) begin
                chain[i] <= 32'hA500_0000 | (32'(i) * 32'h0001_0101);
            end
        end else if (ff_se) begin
            for (int i = 0; i < `EMU_SCAN_WORDS - 1; i++) begin
                chain[i] <= chain[i+1];
            end
            chain[`EMU_SCAN_WORDS-1] <= ff_di;
        end else if (run_mode) begin
            // One target tick
            chain[0] <= chain[0] + 1'b1;
        end
    end

endmodule

// File: sim/tb_emu_top.sv
`timescale 1ns/1ps

`include "emu_consts.svh"

module tb_emu_top;
    import emu_pkg::*;

    localparam int K_WR      = 0;
    localparam int K_RD      = 1;
    localparam int K_POLL    = 2;
    localparam int K_HOLD_RD = 3;
    localparam int K_HOLD    = 4;
    localparam int K_DRAIN   = 5;
    localparam int K_RST     = 6;
    localparam int K_MODE    = 7;
    localparam int K_END     = 8;

    // Roughly ten times the cycles the five tests need
    localparam int MAX_CYCLES = 4000;
    localparam int POLL_LIMIT = 200;
    localparam int STEP_N     = 37;
    localparam int TRIG_K     = 5;
    localparam int STEP_BIG   = 1000;

    logic                        host_clk;
    logic                        host_rst;
    logic                        cmd_valid;
    cmd_op_e                     cmd_op;
    logic [`EMU_ADDR_W-1:0]      cmd_addr;
    logic [`EMU_DATA_W-1:0]      cmd_wdata;
    logic                        cmd_credit;
    logic                        rsp_valid;
    logic [`EMU_DATA_W-1:0]      rsp_rdata;
    logic                        rsp_credit;
    logic                        run_mode;
    logic                        scan_mode;
    logic [`EMU_RESET_COUNT-1:0] rst;
    logic                        ff_se;
    logic [`EMU_DATA_W-1:0]      ff_di;
    logic [`EMU_DATA_W-1:0]      ff_do;
    logic [`EMU_TRIG_COUNT-1:0]  trig;

    // Stimulus table, one entry per queue index
    int                     kind_q [$];
    logic [`EMU_ADDR_W-1:0] addr_q [$];
    logic [`EMU_DATA_W-1:0] wdata_q [$];
    logic [`EMU_DATA_W-1:0] exp_q [$];
    logic [`EMU_DATA_W-1:0] mask_q [$];
    string                  name_q [$];

    // Host side credit and response state
    int                     cmd_cr;
    int                     rsp_owed;
    bit                     hold_rsp;
    logic [`EMU_DATA_W-1:0] rsp_q [$];
    logic [`EMU_DATA_W-1:0] pend_q [$];
    logic [`EMU_ADDR_W-1:0] pend_addr_q [$];

    int                     cycles;
    int                     errors;
    int                     test_errs;
    int                     tests_run;
    int                     tests_failed;
    int                     polls;
    logic [`EMU_DATA_W-1:0] rd_data;
    logic [`EMU_DATA_W-1:0] seed;
    logic [`EMU_DATA_W-1:0] rnd [`EMU_SCAN_WORDS];
    logic [`EMU_DATA_W-1:0] prior [`EMU_SCAN_WORDS];
    logic [`EMU_DATA_W-1:0] word_a;

    emu_top i_emu_top (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_credit (rsp_credit),
        .run_mode   (run_mode),
        .scan_mode  (scan_mode),
        .rst        (rst),
        .ff_se      (ff_se),
        .ff_di      (ff_di),
        .ff_do      (ff_do),
        .trig       (trig)
    );

    emu_target_model i_target (
        .host_clk (host_clk),
        .host_rst (host_rst),
        .run_mode (run_mode),
        .ff_se    (ff_se),
        .ff_di    (ff_di),
        .ff_do    (ff_do),
        .trig     (trig)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Chain contents the target comes out of reset with
    function automatic logic [31:0] chain_reset_word(input int idx);
        return 32'hA500_0000 | (32'(idx) * 32'h0001_0101);
    endfunction

    task automatic add_entry(input int kind, input logic [9:0] addr, input logic [31:0] wdata,
                             input logic [31:0] exp, input logic [31:0] mask);
        kind_q.push_back(kind);
        addr_q.push_back(addr);
        wdata_q.push_back(wdata);
        exp_q.push_back(exp);
        mask_q.push_back(mask);
        name_q.push_back("");
    endtask

    task automatic end_test(input string name);
        add_entry(K_END, '0, '0, '0, '0);
        name_q[name_q.size()-1] = name;
    endtask

    task automatic wait_cycle();
        @(posedge host_clk);
        #1;
    endtask

    task automatic send_cmd(input cmd_op_e op, input logic [9:0] addr, input logic [31:0] wdata);
        while (cmd_cr == 0) begin
            wait_cycle();
        end
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_wdata = wdata;
        cmd_cr--;
        wait_cycle();
        cmd_valid = 1'b0;
    endtask

    task automatic read_reg(input logic [9:0] addr, output logic [31:0] data);
        send_cmd(CMD_READ, addr, '0);
        while (rsp_q.size() == 0) begin
            wait_cycle();
        end
        data = rsp_q.pop_front();
    endtask

    task automatic check_value(input string name, input logic [9:0] addr,
                               input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s at 0x%h: got 0x%h expected 0x%h", name, addr, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        errors++;
        test_errs++;
    endtask

    initial begin
        host_clk = 1'b0;
        forever #10 host_clk = ~host_clk;
    end

    // Credits and responses seen at each edge, plus the run limit
    always @(posedge host_clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end else if (!host_rst) begin
            if (cmd_credit) begin
                cmd_cr++;
                if (cmd_cr > `EMU_CMD_DEPTH) begin
                    report_error("Command credits returned exceed the FIFO depth");
                end
            end
            if (rsp_valid) begin
                rsp_q.push_back(rsp_rdata);
                rsp_owed++;
            end
        end
    end

    // Give one response credit back per cycle unless held
    always @(posedge host_clk) begin
        #1;
        if (!hold_rsp && rsp_owed > 0) begin
            rsp_credit = 1'b1;
            rsp_owed--;
        end else begin
            rsp_credit = 1'b0;
        end
    end

    task automatic build_table();
        // Reset values, readback, unmapped
        add_entry(K_RD, `EMU_REG_RUN_CTRL, '0, 32'h0, '1);
        add_entry(K_RD, `EMU_REG_TRIG_EN, '0, 32'h0, '1);
        add_entry(K_RD, `EMU_REG_RESET_CTRL, '0, 32'h0, '1);
        add_entry(K_WR, `EMU_REG_TRIG_EN, 32'h0000_00A5, '0, '0);
        add_entry(K_RD, `EMU_REG_TRIG_EN, '0, 32'h0000_00A5, '1);
        add_entry(K_WR, `EMU_REG_RESET_CTRL, 32'hFFFF_FFF9, '0, '0);
        add_entry(K_RD, `EMU_REG_RESET_CTRL, '0, 32'h9, '1);
        add_entry(K_RST, `EMU_REG_RESET_CTRL, '0, 32'h9, '1);
        add_entry(K_WR, `EMU_REG_RUN_CTRL, 32'h2, '0, '0);
        add_entry(K_RD, `EMU_REG_RUN_CTRL, '0, 32'h2, '1);
        add_entry(K_MODE, `EMU_REG_RUN_CTRL, '0, 32'h1, '1);
        add_entry(K_WR, `EMU_REG_RUN_CTRL, 32'h0, '0, '0);
        add_entry(K_WR, `EMU_REG_RESET_CTRL, 32'h0, '0, '0);
        add_entry(K_RD, 10'h3FF, '0, 32'h0, '1);
        add_entry(K_MODE, `EMU_REG_RUN_CTRL, '0, 32'h0, '1);
        add_entry(K_RST, `EMU_REG_RESET_CTRL, '0, 32'h0, '1);
        end_test("reset_readback");

        add_entry(K_WR, `EMU_REG_TICK_CNT_LO, 32'h0, '0, '0);
        add_entry(K_WR, `EMU_REG_TICK_CNT_HI, 32'h0, '0, '0);
        add_entry(K_WR, `EMU_REG_TICK_STEP, 32'(STEP_N), '0, '0);
        add_entry(K_WR, `EMU_REG_RUN_CTRL, 32'h1, '0, '0);
        add_entry(K_POLL, `EMU_REG_RUN_CTRL, '0, 32'h0, 32'h1);
        add_entry(K_RD, `EMU_REG_TICK_CNT_LO, '0, 32'(STEP_N), '1);
        add_entry(K_RD, `EMU_REG_TICK_CNT_HI, '0, 32'h0, '1);
        add_entry(K_RD, `EMU_REG_TICK_STEP, '0, 32'h0, '1);
        end_test("stepping");

        // Target word 0 has counted the stepped ticks
        seed = 32'd24;
        for (int i = 0; i < `EMU_SCAN_WORDS; i++) begin
            seed = xorshift(seed);
            rnd[i] = seed;
            prior[i] = chain_reset_word(i) + ((i == 0) ? 32'(STEP_N) : 32'h0);
            add_entry(K_WR, `EMU_REG_SCAN_BUF | 10'(i), rnd[i], '0, '0);
        end
        add_entry(K_WR, `EMU_REG_SCAN_CTRL, 32'h1, '0, '0);
        add_entry(K_POLL, `EMU_REG_SCAN_CTRL, '0, 32'h0, 32'h1);
        for (int i = 0; i < `EMU_SCAN_WORDS; i++) begin
            add_entry(K_RD, `EMU_REG_SCAN_BUF | 10'(i), '0, prior[i], '1);
        end
        add_entry(K_WR, `EMU_REG_SCAN_CTRL, 32'h1, '0, '0);
        add_entry(K_POLL, `EMU_REG_SCAN_CTRL, '0, 32'h0, 32'h1);
        for (int i = 0; i < `EMU_SCAN_WORDS; i++) begin
            add_entry(K_RD, `EMU_REG_SCAN_BUF | 10'(i), '0, rnd[i], '1);
        end
        end_test("scan_swap");

        // Word 0 meets word 1 after K ticks and the pause follows one tick later
        word_a = xorshift(seed);
        add_entry(K_WR, `EMU_REG_SCAN_BUF, word_a, '0, '0);
        add_entry(K_WR, `EMU_REG_SCAN_BUF | 10'h1, word_a + 32'(TRIG_K), '0, '0);
        add_entry(K_WR, `EMU_REG_SCAN_CTRL, 32'h1, '0, '0);
        add_entry(K_POLL, `EMU_REG_SCAN_CTRL, '0, 32'h0, 32'h1);
        add_entry(K_WR, `EMU_REG_TICK_CNT_LO, 32'h0, '0, '0);
        add_entry(K_WR, `EMU_REG_TICK_CNT_HI, 32'h0, '0, '0);
        add_entry(K_WR, `EMU_REG_TRIG_EN, 32'h1, '0, '0);
        add_entry(K_WR, `EMU_REG_TICK_STEP, 32'(STEP_BIG), '0, '0);
        add_entry(K_WR, `EMU_REG_RUN_CTRL, 32'h1, '0, '0);
        add_entry(K_POLL, `EMU_REG_RUN_CTRL, '0, 32'h0, 32'h1);
        add_entry(K_RD, `EMU_REG_TICK_CNT_LO, '0, 32'(TRIG_K + 1), '1);
        add_entry(K_RD, `EMU_REG_TRIG_STAT, '0, 32'h1, '1);
        end_test("trigger_pause");

        add_entry(K_HOLD, '0, '0, '0, '0);
        add_entry(K_HOLD_RD, `EMU_REG_TICK_CNT_LO, '0, 32'(TRIG_K + 1), '1);
        add_entry(K_HOLD_RD, `EMU_REG_TRIG_EN, '0, 32'h1, '1);
        add_entry(K_HOLD_RD, `EMU_REG_TICK_STEP, '0, 32'(STEP_BIG - TRIG_K - 1), '1);
        add_entry(K_HOLD_RD, `EMU_REG_SCAN_BUF | 10'h1, '0, prior[1], '1);
        add_entry(K_DRAIN, '0, '0, '0, '0);
        end_test("credit_backpressure");
    endtask

    task automatic drain_responses();
        repeat (20) wait_cycle();
        if (rsp_q.size() > `EMU_RSP_CREDITS) begin
            report_error("More responses arrived than the port had credits for");
        end
        if (cmd_cr != `EMU_CMD_DEPTH - `EMU_RSP_CREDITS) begin
            report_error("Command credits came back for reads still waiting in the FIFO");
        end
        hold_rsp = 1'b0;
        while (rsp_q.size() < pend_q.size()) begin
            wait_cycle();
        end
        while (pend_q.size() > 0) begin
            check_value("rsp_rdata", pend_addr_q.pop_front(), rsp_q.pop_front(),
                        pend_q.pop_front());
        end
    endtask

    initial begin
        cmd_valid    = 1'b0;
        cmd_op       = CMD_WRITE;
        cmd_addr     = '0;
        cmd_wdata    = '0;
        rsp_credit   = 1'b0;
        host_rst     = 1'b1;
        cmd_cr       = `EMU_CMD_DEPTH;
        rsp_owed     = 0;
        hold_rsp     = 1'b0;
        cycles       = 0;
        errors       = 0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        build_table();
        repeat (10) @(posedge host_clk);
        #1;
        host_rst = 1'b0;
        wait_cycle();

        for (int n = 0; n < kind_q.size(); n++) begin
            case (kind_q[n])
                K_WR: send_cmd(CMD_WRITE, addr_q[n], wdata_q[n]);
                K_RD: begin
                    read_reg(addr_q[n], rd_data);
                    check_value("rsp_rdata", addr_q[n], rd_data & mask_q[n], exp_q[n]);
                end
                K_POLL: begin
                    polls = 0;
                    read_reg(addr_q[n], rd_data);
                    while ((rd_data & mask_q[n]) != exp_q[n] && polls < POLL_LIMIT) begin
                        read_reg(addr_q[n], rd_data);
                        polls++;
                    end
                    if ((rd_data & mask_q[n]) != exp_q[n]) begin
                        report_error($sformatf("Polling address 0x%h never reached 0x%h",
                                               addr_q[n], exp_q[n]));
                    end
                end
                K_RST: check_value("rst", addr_q[n], 32'(rst), exp_q[n]);
                K_MODE: check_value("scan_mode", addr_q[n], 32'(scan_mode), exp_q[n]);
                K_HOLD: begin
                    while (rsp_owed != 0 || rsp_q.size() != 0) begin
                        wait_cycle();
                    end
                    repeat (2) wait_cycle();
                    hold_rsp = 1'b1;
                end
                K_HOLD_RD: begin
                    send_cmd(CMD_READ, addr_q[n], '0);
                    pend_q.push_back(exp_q[n]);
                    pend_addr_q.push_back(addr_q[n]);
                end
                K_DRAIN: drain_responses();
                default: begin
                    tests_run++;
                    if (test_errs == 0) begin
                        $display("test %s: ok", name_q[n]);
                    end else begin
                        $display("test %s: %0d errors", name_q[n], test_errs);
                        tests_failed++;
                    end
                    test_errs = 0;
                end
            endcase
        end

        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+rtl
rtl/emu_pkg.sv
rtl/host_cmd_port.sv
rtl/emu_ctrl.sv
rtl/scan_chain_ctrl.sv
rtl/emu_top.sv
sim/emu_target_model.sv
sim/tb_emu_top.sv
